/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_rv_core
FLIST     := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Simulation failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [1:0] {
    S_RESET  = 2'd0,
    S_EXEC   = 2'd1,
    S_HALT   = 2'd2,
    S_RESUME = 2'd3
  } run_state_e;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_8000;

  // Upper byte of a debug address for the GPR window
  localparam logic [7:0] DBG_REG_PAGE = 8'h10;

  // Data memory request, one level per cycle
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dmem_req_t;

  // Abstract register access
  typedef struct packed {
    logic        en;
    logic        wr;
    logic [15:0] ad;
    logic [31:0] di;
  } dbg_req_t;

endpackage

`default_nettype wire

/* list.f */
rv_isa_pkg.sv
core_ctrl_pkg.sv
rv_decode.sv
rv_exec.sv
rv_lsu.sv
rv_regfile.sv
rv_run_ctrl.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  wire           CLK,
  input  wire           RST_N,
  // Instruction memory
  output logic          imem_valid,
  output xlen_t         imem_addr,
  input  wire           imem_ready,
  input  wire xlen_t    imem_rdata,
  // Data memory
  output dmem_req_t     dmem_req,
  input  wire           dmem_ready,
  input  wire xlen_t    dmem_rdata,
  // Run control
  input  wire           haltreq,
  input  wire           resumereq,
  output logic          halted,
  output logic          resuming,
  output logic          running,
  // Abstract register access
  input  wire dbg_req_t dbg_req,
  output xlen_t         dbg_rdata
);

  insn_u   fetch_insn;
  dec_op_t dec;
  xlen_t   pc;
  xlen_t   next_pc;
  xlen_t   result;
  xlen_t   mem_addr;
  xlen_t   load_data;
  xlen_t   rs1_data;
  xlen_t   rs2_data;
  xlen_t   rd_wdata;
  logic    exec_en;
  logic    stall;
  logic    rf_we;

  // Missing fetch executes a NOP
  assign fetch_insn = imem_ready ? imem_rdata : NOP_WORD;
  assign imem_valid = exec_en;
  assign imem_addr  = pc;

  assign rf_we    = exec_en & ~stall & dec.we;
  assign rd_wdata = (dec.cls == LOAD) ? load_data : result;

  rv_run_ctrl run_ctrl_i (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .haltreq    (haltreq),
    .resumereq  (resumereq),
    .is_halt_op (dec.cls == HALT),
    .stall      (stall),
    .next_pc    (next_pc),
    .pc         (pc),
    .exec_en    (exec_en),
    .halted     (halted),
    .resuming   (resuming),
    .running    (running)
  );

  rv_decode decode_i (
    .insn (fetch_insn),
    .dec  (dec)
  );

  rv_regfile regfile_i (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .we        (rf_we),
    .rd        (dec.rd),
    .wdata     (rd_wdata),
    .rs1       (dec.rs1),
    .rs2       (dec.rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .halted    (halted),
    .dbg_req   (dbg_req),
    .dbg_rdata (dbg_rdata)
  );

  rv_exec exec_i (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result),
    .mem_addr (mem_addr),
    .next_pc  (next_pc)
  );

  rv_lsu lsu_i (
    .dec        (dec),
    .exec_en    (exec_en),
    .mem_addr   (mem_addr),
    .rs2_data   (rs2_data),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data),
    .stall      (stall)
  );

endmodule

`default_nettype wire

/* rv_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_props import core_ctrl_pkg::*; (
  input wire            CLK,
  input wire            RST_N,
  input wire            halted,
  input wire            resuming,
  input wire            running,
  input wire            imem_valid,
  input wire dmem_req_t dmem_req,
  input wire            dmem_ready,
  input wire dbg_req_t  dbg_req,
  input wire            rf_we,
  input wire [4:0]      rf_rd,
  input wire [31:0]     regs [1:31]
);

  // Run status outputs are mutually exclusive
  a_status_onehot: assert property (@(posedge CLK) disable iff (!RST_N)
    $onehot0({halted, resuming, running}))
    else $error("more than one run status output is high");

  // Stalled request must not move
  a_req_stable: assert property (@(posedge CLK) disable iff (!RST_N)
    (dmem_req.valid && !dmem_ready) |=> $stable(dmem_req))
    else $error("dmem request changed while waiting for ready");

  a_no_fetch_halted: assert property (@(posedge CLK) disable iff (!RST_N)
    halted |-> !imem_valid)
    else $error("instruction fetch while halted");

  // A debug write outside halt leaves its target register alone
  for (genvar g = 1; g < 32; g++) begin : g_dbg_reg
    a_dbg_write_halted: assert property (@(posedge CLK) disable iff (!RST_N)
      (!halted && dbg_req.en && dbg_req.wr && (dbg_req.ad[4:0] == g) &&
       !(rf_we && (rf_rd == g))) |=> $stable(regs[g]))
      else $error("debug write changed x%0d outside halt", g);
  end

endmodule

bind rv_core rv_core_props props_i (
  .CLK        (CLK),
  .RST_N      (RST_N),
  .halted     (halted),
  .resuming   (resuming),
  .running    (running),
  .imem_valid (imem_valid),
  .dmem_req   (dmem_req),
  .dmem_ready (dmem_ready),
  .dbg_req    (dbg_req),
  .rf_we      (rf_we),
  .rf_rd      (dec.rd),
  .regs       (regfile_i.regs)
);

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_isa_pkg::*; (
  input  wire insn_u   insn,
  output dec_op_t      dec
);

  logic [2:0] f3;
  logic [6:0] f7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  assign f3 = insn.r.funct3;
  assign f7 = insn.r.funct7;

  // Immediates of each format
  assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
  assign imm_s = {{20{insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'h000};
  assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  // alt selects SUB or SRA
  function automatic alu_op_e map_alu(input logic [2:0] fn3, input logic alt);
    case (fn3)
      F3_ADD:  return alt ? SUB : ADD;
      F3_SLL:  return SLL;
      F3_SLT:  return SLT;
      F3_SLTU: return SLTU;
      F3_XOR:  return XOR;
      F3_SR:   return alt ? SRA : SRL;
      F3_OR:   return OR;
      F3_AND:  return AND;
      default: return ADD;
    endcase
  endfunction

  always_comb begin
    dec        = '0;
    dec.cls    = NONE;
    dec.alu    = ADD;
    dec.funct3 = f3;
    dec.rd     = insn.r.rd;
    dec.rs1    = insn.r.rs1;
    dec.rs2    = insn.r.rs2;
    case (insn.r.opcode)
      OPC_LUI: begin
        dec.cls   = ALU;
        dec.alu   = PASS_B;
        dec.imm   = imm_u;
        dec.b_imm = 1'b1;
        dec.we    = 1'b1;
      end
      OPC_AUIPC: begin
        dec.cls   = ALU;
        dec.imm   = imm_u;
        dec.b_imm = 1'b1;
        dec.a_pc  = 1'b1;
        dec.we    = 1'b1;
      end
      OPC_JAL: begin
        dec.cls   = JUMP;
        dec.imm   = imm_j;
        dec.b_imm = 1'b1;
        dec.a_pc  = 1'b1;
        dec.we    = 1'b1;
      end
      OPC_JALR: begin
        dec.cls     = JUMP;
        dec.imm     = imm_i;
        dec.b_imm   = 1'b1;
        dec.we      = 1'b1;
        dec.illegal = (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        dec.cls     = BRANCH;
        dec.imm     = imm_b;
        dec.illegal = (f3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        dec.cls     = LOAD;
        dec.imm     = imm_i;
        dec.b_imm   = 1'b1;
        dec.we      = 1'b1;
        dec.illegal = (f3 == 3'd3) || (f3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        dec.cls     = STORE;
        dec.imm     = imm_s;
        dec.b_imm   = 1'b1;
        dec.illegal = (f3 > F3_W);
      end
      OPC_OP_IMM: begin
        dec.cls     = ALU;
        dec.alu     = map_alu(f3, (f3 == F3_SR) && f7[5]);
        dec.imm     = imm_i;
        dec.b_imm   = 1'b1;
        dec.we      = 1'b1;
        dec.illegal = ((f3 == F3_SLL) && (f7 != 7'h00)) ||
                      ((f3 == F3_SR) && (f7 != 7'h00) && (f7 != 7'h20));
      end
      OPC_OP: begin
        dec.cls     = ALU;
        dec.alu     = map_alu(f3, f7[5]);
        dec.we      = 1'b1;
        dec.illegal = (f7 != 7'h00) &&
                      !((f7 == 7'h20) && ((f3 == F3_ADD) || (f3 == F3_SR)));
      end
      OPC_MISC_MEM: begin
        // FENCE runs as a plain NOP
        dec.cls = NONE;
      end
      OPC_SYSTEM: begin
        if ((insn.i.imm == 12'd1) && (insn.i.rs1 == '0) && (f3 == 3'd0) &&
            (insn.i.rd == '0)) begin
          dec.cls = HALT;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase
    // Unknown words retire with no effect
    if (dec.illegal) begin
      dec.cls = NONE;
      dec.we  = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec import rv_isa_pkg::*; (
  input  wire dec_op_t dec,
  input  wire xlen_t   pc,
  input  wire xlen_t   rs1_data,
  input  wire xlen_t   rs2_data,
  output xlen_t        result,
  output xlen_t        mem_addr,
  output xlen_t        next_pc
);

  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_out;
  xlen_t pc_plus4;
  xlen_t pc_target;
  logic  branch_taken;

  assign op_a      = dec.a_pc ? pc : rs1_data;
  assign op_b      = dec.b_imm ? dec.imm : rs2_data;
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (dec.alu)
      ADD:     alu_out = op_a + op_b;
      SUB:     alu_out = op_a - op_b;
      SLL:     alu_out = op_a << op_b[4:0];
      SLT:     alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      SLTU:    alu_out = {31'd0, op_a < op_b};
      XOR:     alu_out = op_a ^ op_b;
      SRL:     alu_out = op_a >> op_b[4:0];
      SRA:     alu_out = xlen_t'($signed(op_a) >>> op_b[4:0]);
      OR:      alu_out = op_a | op_b;
      AND:     alu_out = op_a & op_b;
      PASS_B:  alu_out = op_b;
      default: alu_out = '0;
    endcase
  end

  // Branch compare always works on the two registers
  always_comb begin
    case (dec.funct3)
      F3_BEQ:  branch_taken = (rs1_data == rs2_data);
      F3_BNE:  branch_taken = (rs1_data != rs2_data);
      F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: branch_taken = (rs1_data < rs2_data);
      F3_BGEU: branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

  // Jumps write the link value
  assign result   = (dec.cls == JUMP) ? pc_plus4 : alu_out;
  assign mem_addr = alu_out;

  //////////////////////////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    next_pc = pc_plus4;
    if ((dec.cls == BRANCH) && branch_taken) begin
      next_pc = pc_target;
    end else if ((dec.cls == JUMP) && dec.a_pc) begin
      next_pc = pc_target;
    end else if (dec.cls == JUMP) begin
      // JALR drops bit 0
      next_pc = {alu_out[31:1], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // ALU funct3
  localparam logic [2:0] F3_ADD  = 3'd0;
  localparam logic [2:0] F3_SLL  = 3'd1;
  localparam logic [2:0] F3_SLT  = 3'd2;
  localparam logic [2:0] F3_SLTU = 3'd3;
  localparam logic [2:0] F3_XOR  = 3'd4;
  localparam logic [2:0] F3_SR   = 3'd5;
  localparam logic [2:0] F3_OR   = 3'd6;
  localparam logic [2:0] F3_AND  = 3'd7;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;
  localparam logic [2:0] F3_BLTU = 3'd6;
  localparam logic [2:0] F3_BGEU = 3'd7;

  // Memory access widths
  localparam logic [2:0] F3_B  = 3'd0;
  localparam logic [2:0] F3_H  = 3'd1;
  localparam logic [2:0] F3_W  = 3'd2;
  localparam logic [2:0] F3_BU = 3'd4;
  localparam logic [2:0] F3_HU = 3'd5;

  // ADDI x0, x0, 0
  localparam xlen_t NOP_WORD = 32'h0000_0013;

  ///////////////////////////////////////////////////////////////////////
  // Instruction formats
  ///////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } fmt_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } fmt_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } fmt_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } fmt_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } fmt_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } fmt_j_t;

  typedef union packed {
    fmt_r_t r;
    fmt_i_t i;
    fmt_s_t s;
    fmt_b_t b;
    fmt_u_t u;
    fmt_j_t j;
  } insn_u;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    ALU, LOAD, STORE, BRANCH, JUMP, HALT, NONE
  } op_class_e;

  typedef struct packed {
    op_class_e  cls;
    alu_op_e    alu;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      imm;
    logic       b_imm;
    logic       a_pc;
    logic       we;
    logic       illegal;
  } dec_op_t;

endpackage

`default_nettype wire

/* rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  wire dec_op_t dec,
  input  wire          exec_en,
  input  wire xlen_t   mem_addr,
  input  wire xlen_t   rs2_data,
  output dmem_req_t    dmem_req,
  input  wire          dmem_ready,
  input  wire xlen_t   dmem_rdata,
  output xlen_t        load_data,
  output logic         stall
);

  logic        is_load;
  logic        is_store;
  logic [3:0]  wstb;
  xlen_t       wdata;
  xlen_t       lane_shift;
  logic [15:0] ld_half;

  assign is_load  = (dec.cls == LOAD);
  assign is_store = (dec.cls == STORE);

  // Store lanes
  always_comb begin
    wstb  = 4'b0000;
    wdata = '0;
    if (is_store) begin
      case (dec.funct3)
        F3_B: begin
          wdata = {4{rs2_data[7:0]}};
          wstb  = 4'b0001 << mem_addr[1:0];
        end
        F3_H: begin
          wdata = {2{rs2_data[15:0]}};
          wstb  = mem_addr[1] ? 4'b1100 : 4'b0011;
        end
        F3_W: begin
          wdata = rs2_data;
          wstb  = 4'b1111;
        end
        default: wstb = 4'b0000;
      endcase
    end
  end

  assign dmem_req = '{valid: exec_en & (is_load | is_store),
                      wstb:  wstb,
                      addr:  mem_addr,
                      wdata: wdata};

  assign stall = dmem_req.valid & ~dmem_ready;

  // Load lane pick and extension
  assign lane_shift = dmem_rdata >> {mem_addr[1:0], 3'b000};
  assign ld_half    = mem_addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (dec.funct3)
      F3_B:    load_data = {{24{lane_shift[7]}}, lane_shift[7:0]};
      F3_BU:   load_data = {24'd0, lane_shift[7:0]};
      F3_H:    load_data = {{16{ld_half[15]}}, ld_half};
      F3_HU:   load_data = {16'd0, ld_half};
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  wire           CLK,
  input  wire           RST_N,
  input  wire           we,
  input  wire reg_idx_t rd,
  input  wire xlen_t    wdata,
  input  wire reg_idx_t rs1,
  input  wire reg_idx_t rs2,
  output xlen_t         rs1_data,
  output xlen_t         rs2_data,
  input  wire           halted,
  input  wire dbg_req_t dbg_req,
  output xlen_t         dbg_rdata
);

  // x0 has no storage
  xlen_t    regs [1:31];
  logic     dbg_hit;
  logic     dbg_we;
  reg_idx_t dbg_idx;

  assign dbg_hit = halted & dbg_req.en & (dbg_req.ad[15:8] == DBG_REG_PAGE);
  assign dbg_we  = dbg_hit & dbg_req.wr;
  assign dbg_idx = dbg_req.ad[4:0];

  always_ff @(posedge CLK) begin
    if (RST_N) begin
      if (we && (rd != '0)) begin
        regs[rd] <= wdata;
      end else if (dbg_we && (dbg_idx != '0)) begin
        regs[dbg_idx] <= dbg_req.di;
      end
    end
  end

  assign rs1_data  = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data  = (rs2 == '0) ? '0 : regs[rs2];
  assign dbg_rdata = (dbg_hit && (dbg_idx != '0)) ? regs[dbg_idx] : '0;

endmodule

`default_nettype wire

/* rv_run_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_run_ctrl import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  wire        CLK,
  input  wire        RST_N,
  input  wire        haltreq,
  input  wire        resumereq,
  input  wire        is_halt_op,
  input  wire        stall,
  input  wire xlen_t next_pc,
  output xlen_t      pc,
  output logic       exec_en,
  output logic       halted,
  output logic       resuming,
  output logic       running
);

  run_state_e state;
  logic       haltreq_q;
  logic       step;

  // A pending halt request cancels the instruction of its cycle
  assign exec_en = (state == S_EXEC) & ~haltreq_q;
  assign step    = exec_en & ~stall;

  // Sampled only between instructions
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      haltreq_q <= 1'b0;
    end else if (!stall) begin
      haltreq_q <= haltreq;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run state
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= S_RESET;
    end else begin
      case (state)
        S_RESET: state <= S_EXEC;
        S_EXEC: begin
          if (haltreq_q || (step && is_halt_op)) begin
            state <= S_HALT;
          end
        end
        S_HALT: begin
          if (resumereq) begin
            state <= S_RESUME;
          end
        end
        S_RESUME: begin
          if (!resumereq) begin
            state <= S_EXEC;
          end
        end
        default: state <= S_RESET;
      endcase
    end
  end

  // EBREAK leaves PC+4 here through next_pc
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      pc <= BOOT_ADDR;
    end else if (step) begin
      pc <= next_pc;
    end
  end

  assign halted   = (state == S_HALT);
  assign resuming = (state == S_RESUME);
  assign running  = (state == S_RESET) | (state == S_EXEC);

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*, core_ctrl_pkg::*; ();

  localparam int NT   = 5;
  localparam int MAXI = 24;
  localparam int MAXR = 20;
  localparam int MAXS = 8;
  localparam xlen_t EBREAK_WORD = 32'h0010_0073;

  logic      CLK;
  logic      RST_N;
  logic      imem_valid;
  xlen_t     imem_addr;
  logic      imem_ready;
  xlen_t     imem_rdata;
  dmem_req_t dmem_req;
  logic      dmem_ready;
  xlen_t     dmem_rdata;
  logic      haltreq;
  logic      resumereq;
  logic      halted;
  logic      resuming;
  logic      running;
  dbg_req_t  dbg_req;
  xlen_t     dbg_rdata;

  // Test table
  xlen_t      tab_code [NT][MAXI];
  int         tab_ncode [NT];
  reg_idx_t   tab_rreg [NT][MAXR];
  xlen_t      tab_rval [NT][MAXR];
  int         tab_nreg [NT];
  logic [3:0] tab_stb [NT][MAXS];
  xlen_t      tab_swd [NT][MAXS];
  int         tab_nst [NT];
  bit         tab_hreq [NT];

  xlen_t      prog [64];
  xlen_t      mem [64];
  logic [3:0] seen_stb [$];
  xlen_t      seen_wd [$];
  int         dly;
  xlen_t      pidx;
  int         errors;
  int         timeouts;

  rv_core rv_core_i (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////////////////////////////////////
  assign pidx       = (imem_addr - BOOT_ADDR) >> 2;
  assign imem_rdata = (pidx < 64) ? prog[pidx[5:0]] : '0;
  assign dmem_rdata = mem[dmem_req.addr[7:2]];

  function automatic xlen_t mem_fill(input int i);
    return 32'h5A00_0000 ^ (i * 32'h0001_0203);
  endfunction

  // Each request waits 0 to 2 cycles drawn as the previous one ends
  always @(posedge CLK) begin
    if (dmem_req.valid && dmem_ready) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.wstb[b]) begin
          mem[dmem_req.addr[7:2]][8*b +: 8] = dmem_req.wdata[8*b +: 8];
        end
      end
      if (dmem_req.wstb != 4'b0000) begin
        seen_stb.push_back(dmem_req.wstb);
        seen_wd.push_back(dmem_req.wdata);
      end
      dly = $urandom % 3;
      dmem_ready <= (dly == 0);
    end else if (dmem_req.valid && !dmem_ready) begin
      dly = dly - 1;
      dmem_ready <= (dly == 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////////////////
  function automatic xlen_t enc_i(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, int imm);
    logic [11:0] v;
    v = imm[11:0];
    return {v, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic xlen_t enc_s(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1, int imm);
    logic [11:0] v;
    v = imm[11:0];
    return {v[11:5], rs2, rs1, f3, v[4:0], OPC_STORE};
  endfunction

  function automatic xlen_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, int imm);
    logic [12:0] v;
    v = imm[12:0];
    return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], OPC_BRANCH};
  endfunction

  function automatic xlen_t enc_u(logic [6:0] op, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic xlen_t enc_j(reg_idx_t rd, int imm);
    logic [20:0] v;
    v = imm[20:0];
    return {v[20], v[10:1], v[11], v[19:12], rd, OPC_JAL};
  endfunction

  task automatic put(input int t, input xlen_t w);
    tab_code[t][tab_ncode[t]] = w;
    tab_ncode[t]++;
  endtask

  task automatic expect_reg(input int t, input reg_idx_t r, input xlen_t v);
    tab_rreg[t][tab_nreg[t]] = r;
    tab_rval[t][tab_nreg[t]] = v;
    tab_nreg[t]++;
  endtask

  task automatic expect_store(input int t, input logic [3:0] stb, input xlen_t wd);
    tab_stb[t][tab_nst[t]] = stb;
    tab_swd[t][tab_nst[t]] = wd;
    tab_nst[t]++;
  endtask

  task automatic build_table();
    // ALU program
    put(0, enc_i(OPC_OP_IMM, F3_ADD, 1, 0, -20));
    put(0, enc_i(OPC_OP_IMM, F3_ADD, 2, 0, 3));
    put(0, enc_r(7'h00, F3_ADD, 3, 1, 2));
    put(0, enc_r(7'h20, F3_ADD, 4, 2, 1));
    put(0, enc_r(7'h20, F3_SR, 5, 1, 2));
    put(0, enc_r(7'h00, F3_SR, 6, 1, 2));
    put(0, enc_r(7'h00, F3_SLL, 7, 1, 2));
    put(0, enc_r(7'h00, F3_SLT, 8, 1, 2));
    put(0, enc_r(7'h00, F3_SLTU, 9, 1, 2));
    put(0, enc_i(OPC_OP_IMM, F3_XOR, 10, 1, 'h0F0));
    put(0, enc_i(OPC_OP_IMM, F3_AND, 11, 1, 'h07F));
    put(0, enc_r(7'h00, F3_OR, 12, 2, 1));
    put(0, enc_u(OPC_LUI, 13, 20'h12345));
    put(0, enc_u(OPC_AUIPC, 14, 20'h00001));
    put(0, enc_i(OPC_OP_IMM, F3_SR, 15, 1, 'h402));
    put(0, enc_i(OPC_OP_IMM, F3_ADD, 0, 0, 5));
    put(0, enc_i(OPC_OP_IMM, F3_SLT, 16, 1, -19));
    put(0, EBREAK_WORD);
    expect_reg(0, 0, 32'h0);
    expect_reg(0, 1, 32'hFFFF_FFEC);
    expect_reg(0, 2, 32'h3);
    expect_reg(0, 3, 32'hFFFF_FFEF);
    expect_reg(0, 4, 32'h17);
    expect_reg(0, 5, 32'hFFFF_FFFD);
    expect_reg(0, 6, 32'h1FFF_FFFD);
    expect_reg(0, 7, 32'hFFFF_FF60);
    expect_reg(0, 8, 32'h1);
    expect_reg(0, 9, 32'h0);
    expect_reg(0, 10, 32'hFFFF_FF1C);
    expect_reg(0, 11, 32'h6C);
    expect_reg(0, 12, 32'hFFFF_FFEF);
    expect_reg(0, 13, 32'h1234_5000);
    expect_reg(0, 14, 32'h0000_9034);
    expect_reg(0, 15, 32'hFFFF_FFFB);
    expect_reg(0, 16, 32'h1);
    // Stores at every lane
    put(1, enc_u(OPC_LUI, 1, 20'h11223));
    put(1, enc_i(OPC_OP_IMM, F3_ADD, 1, 1, 'h344));
    for (int k = 0; k < 4; k++) begin
      put(1, enc_s(F3_B, 1, 0, 'h10 + k));
      expect_store(1, 4'b0001 << k, 32'h4444_4444);
    end
    put(1, enc_s(F3_H, 1, 0, 'h14));
    put(1, enc_s(F3_H, 1, 0, 'h16));
    put(1, enc_s(F3_W, 1, 0, 'h18));
    put(1, enc_i(OPC_LOAD, F3_W, 2, 0, 'h14));
    put(1, enc_i(OPC_LOAD, F3_W, 3, 0, 'h10));
    put(1, enc_i(OPC_LOAD, F3_W, 4, 0, 'h18));
    put(1, EBREAK_WORD);
    expect_store(1, 4'b0011, 32'h3344_3344);
    expect_store(1, 4'b1100, 32'h3344_3344);
    expect_store(1, 4'b1111, 32'h1122_3344);
    expect_reg(1, 1, 32'h1122_3344);
    expect_reg(1, 2, 32'h3344_3344);
    expect_reg(1, 3, 32'h4444_4444);
    expect_reg(1, 4, 32'h1122_3344);
    // Loads with extension
    put(2, enc_u(OPC_LUI, 1, 20'h8090A));
    put(2, enc_i(OPC_OP_IMM, F3_ADD, 1, 1, 'h0B0));
    put(2, enc_s(F3_W, 1, 0, 'h20));
    put(2, enc_i(OPC_LOAD, F3_B, 2, 0, 'h20));
    put(2, enc_i(OPC_LOAD, F3_BU, 3, 0, 'h20));
    put(2, enc_i(OPC_LOAD, F3_B, 4, 0, 'h21));
    put(2, enc_i(OPC_LOAD, F3_BU, 5, 0, 'h23));
    put(2, enc_i(OPC_LOAD, F3_B, 6, 0, 'h22));
    put(2, enc_i(OPC_LOAD, F3_H, 7, 0, 'h20));
    put(2, enc_i(OPC_LOAD, F3_HU, 8, 0, 'h22));
    put(2, enc_i(OPC_LOAD, F3_H, 9, 0, 'h22));
    put(2, enc_i(OPC_LOAD, F3_W, 10, 0, 'h20));
    put(2, enc_i(OPC_LOAD, F3_W, 11, 0, 'h30));
    put(2, EBREAK_WORD);
    expect_store(2, 4'b1111, 32'h8090_A0B0);
    expect_reg(2, 2, 32'hFFFF_FFB0);
    expect_reg(2, 3, 32'h0000_00B0);
    expect_reg(2, 4, 32'hFFFF_FFA0);
    expect_reg(2, 5, 32'h0000_0080);
    expect_reg(2, 6, 32'hFFFF_FF90);
    expect_reg(2, 7, 32'hFFFF_A0B0);
    expect_reg(2, 8, 32'h0000_8090);
    expect_reg(2, 9, 32'hFFFF_8090);
    expect_reg(2, 10, 32'h8090_A0B0);
    expect_reg(2, 11, mem_fill(12));
    // Branches and jumps with x10 counting the executed markers
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 1, 0, 5));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 2, 0, -1));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 0, 0));
    put(3, enc_b(F3_BEQ, 1, 2, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 1));
    put(3, enc_b(F3_BNE, 1, 2, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 100));
    put(3, enc_b(F3_BLT, 2, 1, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 100));
    put(3, enc_b(F3_BLTU, 2, 1, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 2));
    put(3, enc_b(F3_BGE, 1, 2, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 100));
    put(3, enc_b(F3_BGEU, 2, 1, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 100));
    put(3, enc_j(3, 8));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 100));
    put(3, enc_u(OPC_AUIPC, 4, 20'h0));
    put(3, enc_i(OPC_JALR, 3'd0, 5, 4, 13));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 100));
    put(3, enc_i(OPC_OP_IMM, F3_ADD, 10, 10, 4));
    put(3, EBREAK_WORD);
    expect_reg(3, 3, 32'h0000_8040);
    expect_reg(3, 4, 32'h0000_8044);
    expect_reg(3, 5, 32'h0000_804C);
    expect_reg(3, 10, 32'd7);
    // Spin until the debugger writes x5
    put(4, enc_i(OPC_OP_IMM, F3_ADD, 5, 0, 0));
    put(4, enc_b(F3_BEQ, 5, 0, 0));
    put(4, enc_i(OPC_OP_IMM, F3_ADD, 6, 5, 100));
    put(4, EBREAK_WORD);
    tab_hreq[4] = 1'b1;
    expect_reg(4, 5, 32'd7);
    expect_reg(4, 6, 32'd107);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Checks and handshakes
  ////////////////////////////////////////////////////////////////////////
  task automatic check(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic status(input int sel);
    case (sel)
      0:       return halted;
      1:       return resuming;
      2:       return running;
      default: return imem_valid;
    endcase
  endfunction

  task automatic wait_until(input int sel, input string what);
    int n;
    n = 0;
    @(negedge CLK);
    while (status(sel) !== 1'b1 && n < 500) begin
      @(negedge CLK);
      n++;
    end
    if (status(sel) !== 1'b1) begin
      timeouts++;
      $display("Timeout at %0t while waiting for %s", $time, what);
    end
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    RST_N     <= 1'b0;
    haltreq   <= 1'b0;
    resumereq <= 1'b0;
    repeat (4) @(posedge CLK);
    RST_N <= 1'b1;
    wait_until(3, "first fetch");
    check("imem_addr", imem_addr, BOOT_ADDR);
    check("running", {31'd0, running}, 32'd1);
  endtask

  task automatic dbg_access(input reg_idx_t r, input logic wr, input xlen_t di,
                            output xlen_t rdata);
    @(posedge CLK);
    dbg_req <= '{en: 1'b1, wr: wr, ad: {DBG_REG_PAGE, 3'b000, r}, di: di};
    @(negedge CLK);
    rdata = dbg_rdata;
    @(posedge CLK);
    dbg_req <= '0;
  endtask

  task automatic resume_core();
    @(posedge CLK);
    resumereq <= 1'b1;
    wait_until(1, "resuming");
    @(posedge CLK);
    resumereq <= 1'b0;
    wait_until(2, "running");
  endtask

  task automatic run_test(input int t);
    xlen_t rd_val;
    for (int i = 0; i < 64; i++) begin
      prog[i] = (i < tab_ncode[t]) ? tab_code[t][i] : '0;
      mem[i]  = mem_fill(i);
    end
    seen_stb.delete();
    seen_wd.delete();
    apply_reset();
    if (tab_hreq[t]) begin
      repeat (20) @(posedge CLK);
      haltreq <= 1'b1;
      wait_until(0, "halt on request");
      @(posedge CLK);
      haltreq <= 1'b0;
      dbg_access(5, 1'b1, 32'd7, rd_val);
      dbg_access(5, 1'b0, '0, rd_val);
      check("dbg x5", rd_val, 32'd7);
      resume_core();
    end
    wait_until(0, "EBREAK halt");
    for (int k = 0; k < tab_nreg[t]; k++) begin
      dbg_access(tab_rreg[t][k], 1'b0, '0, rd_val);
      check($sformatf("test %0d x%0d", t, tab_rreg[t][k]), rd_val, tab_rval[t][k]);
    end
    check($sformatf("test %0d store count", t), seen_stb.size(), tab_nst[t]);
    for (int k = 0; k < tab_nst[t] && k < seen_stb.size(); k++) begin
      check($sformatf("test %0d wstb[%0d]", t, k), {28'd0, seen_stb[k]},
            {28'd0, tab_stb[t][k]});
      check($sformatf("test %0d wdata[%0d]", t, k), seen_wd[k], tab_swd[t][k]);
    end
    resume_core();
  endtask

  initial begin
    void'($urandom(32'hba59d15e));
    RST_N      = 1'b0;
    imem_ready = 1'b1;
    dmem_ready = 1'b1;
    haltreq    = 1'b0;
    resumereq  = 1'b0;
    dbg_req    = '0;
    dly        = 0;
    build_table();
    for (int t = 0; t < NT; t++) begin
      run_test(t);
    end
    $display("Errors: %0d mismatches, %0d other failures", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
